// ==== all.f ====
+incdir+.
bootPkg.sv
spiWordReader.sv
imageLoader.sv
bootRam.sv
bootTop.sv
clockGen.sv
spiStorageModel.sv
boot_checker.sv
bootTb.sv

// ==== bootLoad_cfg.svh ====
`ifndef BOOT_LOAD_CFG_SVH
`define BOOT_LOAD_CFG_SVH

// On-chip program RAM depth in 32-bit words
`define BOOT_RAM_WORDS 256

// Address bits needed to index the RAM
`define BOOT_RAM_AW 8

// Word address sent to storage after the command byte
`define BOOT_FLASH_AW 24

// Clock cycles per half SPI clock period
`define BOOT_SPI_DIV 2

// Plain serial flash read opcode
`define BOOT_READ_CMD 8'h03

`endif

// ==== bootPkg.sv ====
`include "bootLoad_cfg.svh"

package bootPkg;

    typedef logic [31:0] wordT;
    typedef logic [`BOOT_RAM_AW-1:0] ramAddrT;
    typedef logic [`BOOT_FLASH_AW-1:0] flashAddrT;

    // Loader asks the SPI reader for one storage word
    typedef struct packed {
        flashAddrT addr;
    } readReqT;

    typedef struct packed {
        wordT data;
    } readRspT;

    // Loader write into program RAM
    typedef struct packed {
        ramAddrT addr;
        wordT    data;
    } ramWriteT;

    // Host access, write flag set means store
    typedef struct packed {
        logic    write;
        ramAddrT addr;
        wordT    data;
    } hostReqT;

    typedef enum logic [1:0] {idle, shift, done} spiStateT;

    typedef enum logic [2:0] {
        fetchLength,
        waitLength,
        fetchWord,
        waitWord,
        booted
    } loadStateT;

endpackage

// ==== bootRam.sv ====
`timescale 1ns/1ps
`include "bootLoad_cfg.svh"

module bootRam (
    input  logic              Clock,
    input  logic              rst,
    input  bootPkg::ramWriteT ramWrite,
    input  logic              ramWriteValid,
    input  logic              booted,
    input  bootPkg::hostReqT  hostReq,
    input  logic              hostReqValid,
    output logic              hostReqReady,
    output bootPkg::wordT     hostRsp,
    output logic              hostRspValid
);

    bootPkg::wordT mem [`BOOT_RAM_WORDS];

    logic hostAccept;
    logic hostRead;

    // Single write port, owner switches at boot
    logic wrEn;
    bootPkg::ramAddrT wrAddr;
    bootPkg::wordT wrData;

    // Host side opens only once the image is in place
    assign hostReqReady = booted;
    assign hostAccept = hostReqValid && hostReqReady;
    assign hostRead = hostAccept && !hostReq.write;

    always_comb begin
        if (booted) begin
            wrEn = hostAccept && hostReq.write;
            wrAddr = hostReq.addr;
            wrData = hostReq.data;
        end else begin
            wrEn = ramWriteValid;
            wrAddr = ramWrite.addr;
            wrData = ramWrite.data;
        end
    end

    always_ff @(posedge Clock) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
        if (hostRead) begin
            hostRsp <= mem[hostReq.addr];
        end
    end

    // One-cycle pulse per accepted read
    always_ff @(posedge Clock) begin
        if (rst) begin
            hostRspValid <= 1'b0;
        end else begin
            hostRspValid <= hostRead;
        end
    end

endmodule

// ==== bootTb.sv ====
`timescale 1ns/1ps
`include "bootLoad_cfg.svh"

module bootTb;

    localparam int ClockPeriod = 20;
    // One SPI word frame plus the handshake turnaround
    localparam int FrameCycles = 260;
    // Frames per test: 21, 1, 9, 257, 5, and 5 + 17 around the reset
    localparam int LoadFrames = 21 + 1 + 9 + 257 + 5 + 22;
    localparam int WatchdogCycles = LoadFrames * FrameCycles + 2000;

    logic Clock;
    logic rst;
    logic spiCs, spiSclk, spiMosi, spiMiso;
    bootPkg::hostReqT hostReq;
    logic hostReqValid, hostReqReady, hostRspValid, booted;
    bootPkg::wordT hostRsp;

    bootPkg::wordT expRam [`BOOT_RAM_WORDS];
    logic [31:0] lcgState;

    clockGen #(.Period(ClockPeriod)) clkGen (.Clock(Clock));

    bootTop DUT (
        .Clock(Clock),
        .rst(rst),
        .spiCs(spiCs),
        .spiSclk(spiSclk),
        .spiMosi(spiMosi),
        .spiMiso(spiMiso),
        .hostReq(hostReq),
        .hostReqValid(hostReqValid),
        .hostReqReady(hostReqReady),
        .hostRsp(hostRsp),
        .hostRspValid(hostRspValid),
        .booted(booted)
    );

    spiStorageModel storage (.spiCs(spiCs), .spiSclk(spiSclk), .spiMosi(spiMosi), .spiMiso(spiMiso));

    bind bootTop boot_checker bootCheck (
        .Clock(Clock), .rst(rst), .spiCs(spiCs), .spiSclk(spiSclk),
        .hostReq(hostReq), .hostReqValid(hostReqValid), .hostReqReady(hostReqReady),
        .hostRspValid(hostRspValid), .booted(booted)
    );

    function automatic bootPkg::wordT nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic checkWord(input bootPkg::wordT actual, input bootPkg::wordT expected,
                             input string what);
        if (actual !== expected) begin
            abortRun($sformatf("Fail at %0t ns: %s, got %h, expected %h",
                               $time, what, actual, expected));
        end
    endtask

    task automatic checkFlag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            abortRun($sformatf("Fail at %0t ns: %s, got %b, expected %b",
                               $time, what, actual, expected));
        end
    endtask

    task automatic stepCycle();
        @(posedge Clock);
        #1;
    endtask

    task automatic resetDut();
        rst = 1'b1;
        repeat (5) stepCycle();
        checkFlag(spiCs, 1'b1, "spiCs in reset");
        checkFlag(spiSclk, 1'b0, "spiSclk in reset");
        checkFlag(booted, 1'b0, "booted in reset");
        checkFlag(hostReqReady, 1'b0, "hostReqReady in reset");
        checkFlag(hostRspValid, 1'b0, "hostRspValid in reset");
        rst = 1'b0;
    endtask

    // Word 0 is the count, words 1 to N the program at RAM 0 to N-1
    task automatic loadImage(input int count);
        storage.clearImage();
        storage.image[0] = bootPkg::wordT'(count);
        for (int i = 1; i <= count; i++) begin
            storage.image[i] = nextRand();
        end
        for (int i = 0; i < count && i < `BOOT_RAM_WORDS; i++) begin
            expRam[i] = storage.image[i + 1];
        end
    endtask

    task automatic waitFrames(input int frames);
        int limit;
        limit = frames * FrameCycles + 20;
        while (storage.frameCount < frames) begin
            checkFlag(booted, 1'b0, "booted during load");
            checkFlag(hostReqReady, 1'b0, "hostReqReady during load");
            if (limit == 0) begin
                abortRun("Timeout: storage frames were not read in time");
            end
            limit--;
            stepCycle();
        end
    endtask

    task automatic waitBoot(input int count);
        int frames;
        int limit;
        frames = (count > `BOOT_RAM_WORDS) ? `BOOT_RAM_WORDS + 1 : count + 1;
        limit = frames * FrameCycles + 20;
        while (!booted) begin
            checkFlag(hostReqReady, 1'b0, "hostReqReady before boot");
            if (limit == 0) begin
                abortRun("Timeout: booted did not rise within the worst-case load time");
            end
            limit--;
            stepCycle();
        end
        checkFlag(hostReqReady, 1'b1, "hostReqReady after boot");
        checkFlag(storage.badCmd, 1'b0, "SPI read command byte");
        checkWord(bootPkg::wordT'(storage.frameCount), bootPkg::wordT'(frames),
                  "storage words read at boot");
    endtask

    task automatic hostWrite(input bootPkg::ramAddrT addr, input bootPkg::wordT data);
        checkFlag(hostReqReady, 1'b1, "hostReqReady for write");
        hostReq = '{write: 1'b1, addr: addr, data: data};
        hostReqValid = 1'b1;
        stepCycle();
        hostReqValid = 1'b0;
    endtask

    task automatic hostRead(input bootPkg::ramAddrT addr, output bootPkg::wordT data);
        checkFlag(hostReqReady, 1'b1, "hostReqReady for read");
        hostReq = '{write: 1'b0, addr: addr, data: '0};
        hostReqValid = 1'b1;
        stepCycle();
        hostReqValid = 1'b0;
        checkFlag(hostRspValid, 1'b1, "hostRspValid one cycle after read");
        data = hostRsp;
    endtask

    task automatic checkRam(input int count);
        bootPkg::wordT data;
        for (int i = 0; i < count && i < `BOOT_RAM_WORDS; i++) begin
            hostRead(bootPkg::ramAddrT'(i), data);
            checkWord(data, expRam[i], $sformatf("RAM word %0d", i));
        end
    endtask

    task automatic testRandomImage();
        loadImage(20);
        resetDut();
        waitBoot(20);
        checkRam(20);
    endtask

    task automatic testZeroLength();
        bootPkg::wordT value;
        bootPkg::wordT data;
        loadImage(0);
        resetDut();
        waitBoot(0);
        value = nextRand();
        hostWrite(8'h3C, value);
        hostRead(8'h3C, data);
        checkWord(data, value, "read back after zero-length boot");
    endtask

    task automatic testHostBlocked();
        loadImage(8);
        resetDut();
        // Word 3 is in RAM address 2 once five frames are done
        waitFrames(5);
        hostReq = '{write: 1'b1, addr: 8'd2, data: ~expRam[2]};
        hostReqValid = 1'b1;
        repeat (10) begin
            checkFlag(hostReqReady, 1'b0, "hostReqReady with write pending");
            stepCycle();
        end
        hostReqValid = 1'b0;
        waitBoot(8);
        checkRam(8);
    endtask

    task automatic testOversized();
        loadImage(300);
        resetDut();
        waitBoot(300);
        checkRam(300);
    endtask

    task automatic testHostTraffic();
        bootPkg::wordT shadow [8];
        bootPkg::wordT value;
        bootPkg::ramAddrT addr;
        loadImage(4);
        resetDut();
        waitBoot(4);
        checkRam(4);
        for (int i = 0; i < 8; i++) begin
            shadow[i] = nextRand();
            hostWrite(bootPkg::ramAddrT'(i), shadow[i]);
        end
        // One request per cycle, few addresses so reads hit recent writes
        for (int n = 0; n < 48; n++) begin
            value = nextRand();
            addr = bootPkg::ramAddrT'(value[2:0]);
            hostReq = '{write: value[3], addr: addr, data: nextRand()};
            hostReqValid = 1'b1;
            stepCycle();
            if (hostReq.write) begin
                checkFlag(hostRspValid, 1'b0, "hostRspValid after write");
                shadow[addr] = hostReq.data;
            end else begin
                checkFlag(hostRspValid, 1'b1, "hostRspValid after read");
                checkWord(hostRsp, shadow[addr], $sformatf("host read of address %0d", addr));
            end
        end
        hostReqValid = 1'b0;
    endtask

    task automatic testResetMidLoad();
        loadImage(12);
        resetDut();
        waitFrames(4);
        // Abort partway through the next frame
        repeat (37) stepCycle();
        loadImage(16);
        resetDut();
        waitBoot(16);
        checkRam(16);
    endtask

    initial begin
        #(WatchdogCycles * ClockPeriod);
        abortRun($sformatf("Timeout: the run did not finish within %0d cycles", WatchdogCycles));
    end

    initial begin
        rst = 1'b1;
        hostReq = '0;
        hostReqValid = 1'b0;
        lcgState = 32'd6;
        testRandomImage();
        testZeroLength();
        testHostBlocked();
        testOversized();
        testHostTraffic();
        testResetMidLoad();
        if (DUT.bootCheck.assertFails == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            abortRun($sformatf("Checker assertions failed %0d times",
                               DUT.bootCheck.assertFails));
        end
    end

endmodule

// ==== bootTop.sv ====
`timescale 1ns/1ps

module bootTop (
    input  logic             Clock,
    input  logic             rst,
    output logic             spiCs,
    output logic             spiSclk,
    output logic             spiMosi,
    input  logic             spiMiso,
    input  bootPkg::hostReqT hostReq,
    input  logic             hostReqValid,
    output logic             hostReqReady,
    output bootPkg::wordT    hostRsp,
    output logic             hostRspValid,
    output logic             booted
);

    // Loader to reader
    bootPkg::readReqT readReq;
    logic readReqValid;
    logic readReqReady;

    // Reader back to loader
    bootPkg::readRspT readRsp;
    logic readRspValid;
    logic readRspReady;

    // Loader into RAM
    bootPkg::ramWriteT ramWrite;
    logic ramWriteValid;

    spiWordReader reader (
        .Clock(Clock),
        .rst(rst),
        .readReq(readReq),
        .readReqValid(readReqValid),
        .readReqReady(readReqReady),
        .readRsp(readRsp),
        .readRspValid(readRspValid),
        .readRspReady(readRspReady),
        .spiCs(spiCs),
        .spiSclk(spiSclk),
        .spiMosi(spiMosi),
        .spiMiso(spiMiso)
    );

    imageLoader loader (
        .Clock(Clock),
        .rst(rst),
        .readReq(readReq),
        .readReqValid(readReqValid),
        .readReqReady(readReqReady),
        .readRsp(readRsp),
        .readRspValid(readRspValid),
        .readRspReady(readRspReady),
        .ramWrite(ramWrite),
        .ramWriteValid(ramWriteValid),
        .booted(booted)
    );

    bootRam ram (
        .Clock(Clock),
        .rst(rst),
        .ramWrite(ramWrite),
        .ramWriteValid(ramWriteValid),
        .booted(booted),
        .hostReq(hostReq),
        .hostReqValid(hostReqValid),
        .hostReqReady(hostReqReady),
        .hostRsp(hostRsp),
        .hostRspValid(hostRspValid)
    );

endmodule

// ==== boot_checker.sv ====
`timescale 1ns/1ps

module boot_checker (
    input logic             Clock,
    input logic             rst,
    input logic             spiCs,
    input logic             spiSclk,
    input bootPkg::hostReqT hostReq,
    input logic             hostReqValid,
    input logic             hostReqReady,
    input logic             hostRspValid,
    input logic             booted
);

    int assertFails = 0;
    logic readAccept;

    assign readAccept = hostReqValid && hostReqReady && !hostReq.write;

    // Mode 0 idles low outside a frame
    sclkIdleLow: assert property (@(posedge Clock) disable iff (rst)
        spiCs |-> !spiSclk)
        else begin
            assertFails++;
            $error("spiSclk high while spiCs is high");
        end

    // Host port stays shut while a storage frame is on the wire
    hostShutDuringFrame: assert property (@(posedge Clock) disable iff (rst)
        !spiCs |-> (!hostReqReady && !booted))
        else begin
            assertFails++;
            $error("hostReqReady or booted high during a storage frame");
        end

    // Two pulses in a row need two reads in a row
    oneRspPerRead: assert property (@(posedge Clock) disable iff (rst)
        (hostRspValid && $past(hostRspValid)) |-> ($past(readAccept) && $past(readAccept, 2)))
        else begin
            assertFails++;
            $error("hostRspValid held without two accepted reads");
        end

endmodule

// ==== clockGen.sv ====
`timescale 1ns/1ps

module clockGen #(
    parameter int Period = 20
) (
    output logic Clock
);

    // Free-running, starts low
    initial begin
        Clock = 1'b0;
        forever #(Period / 2) Clock = ~Clock;
    end

endmodule

// ==== imageLoader.sv ====
`timescale 1ns/1ps
`include "bootLoad_cfg.svh"

module imageLoader (
    input  logic              Clock,
    input  logic              rst,
    output bootPkg::readReqT  readReq,
    output logic              readReqValid,
    input  logic              readReqReady,
    input  bootPkg::readRspT  readRsp,
    input  logic              readRspValid,
    output logic              readRspReady,
    output bootPkg::ramWriteT ramWrite,
    output logic              ramWriteValid,
    output logic              booted
);

    // Remaining count must hold the full RAM depth
    localparam int CountW = $clog2(`BOOT_RAM_WORDS + 1);
    localparam bootPkg::wordT MaxWords = `BOOT_RAM_WORDS;

    bootPkg::loadStateT state;
    bootPkg::flashAddrT reqAddr;
    bootPkg::flashAddrT wordIdx;
    logic [CountW-1:0] remaining;

    logic reqFire;
    logic rspFire;

    assign reqFire = readReqValid && readReqReady;
    assign rspFire = readRspValid && readRspReady;

    assign readReq = '{addr: reqAddr};
    assign readRspReady = (state == bootPkg::waitLength) || (state == bootPkg::waitWord);
    assign booted = (state == bootPkg::booted);

    // Storage word k lands at RAM word k-1
    assign wordIdx = reqAddr - 1'b1;
    assign ramWriteValid = rspFire && (state == bootPkg::waitWord);
    assign ramWrite = '{addr: wordIdx[`BOOT_RAM_AW-1:0], data: readRsp.data};

    always_ff @(posedge Clock) begin
        if (rst) begin
            state <= bootPkg::fetchLength;
            reqAddr <= '0;
            readReqValid <= 1'b0;
            remaining <= '0;
        end else begin
            case (state)
                bootPkg::fetchLength: begin
                    if (reqFire) begin
                        readReqValid <= 1'b0;
                        state <= bootPkg::waitLength;
                    end else begin
                        readReqValid <= 1'b1;
                    end
                end
                bootPkg::waitLength: begin
                    if (rspFire) begin
                        if (readRsp.data == '0) begin
                            state <= bootPkg::booted;
                        end else begin
                            state <= bootPkg::fetchWord;
                            reqAddr <= bootPkg::flashAddrT'(1);
                            readReqValid <= 1'b1;
                            // Oversized images are cut at the RAM depth
                            if (readRsp.data > MaxWords) begin
                                remaining <= CountW'(`BOOT_RAM_WORDS);
                            end else begin
                                remaining <= readRsp.data[CountW-1:0];
                            end
                        end
                    end
                end
                bootPkg::fetchWord: begin
                    if (reqFire) begin
                        readReqValid <= 1'b0;
                        state <= bootPkg::waitWord;
                    end
                end
                bootPkg::waitWord: begin
                    if (rspFire) begin
                        remaining <= remaining - 1'b1;
                        if (remaining == CountW'(1)) begin
                            state <= bootPkg::booted;
                        end else begin
                            // Next request goes out while the RAM takes this word
                            reqAddr <= reqAddr + 1'b1;
                            readReqValid <= 1'b1;
                            state <= bootPkg::fetchWord;
                        end
                    end
                end
                bootPkg::booted: begin
                    // Parked until the next reset
                    readReqValid <= 1'b0;
                end
                default: begin
                    state <= bootPkg::fetchLength;
                end
            endcase
        end
    end

endmodule

// ==== spiStorageModel.sv ====
`timescale 1ns/1ps
`include "bootLoad_cfg.svh"

module spiStorageModel (
    input  logic spiCs,
    input  logic spiSclk,
    input  logic spiMosi,
    output logic spiMiso
);

    localparam int ImageWords = 512;

    bootPkg::wordT image [ImageWords];
    int frameCount;
    logic badCmd;

    // Command byte then word address, as shifted in
    logic [31:0] header;
    bootPkg::wordT outWord;
    int bitIdx;

    task automatic clearImage();
        for (int i = 0; i < ImageWords; i++) begin
            image[i] = 32'hB700_0000 | 32'(i);
        end
        frameCount = 0;
        badCmd = 1'b0;
    endtask

    // Addresses past the array still return something address-dependent
    function automatic bootPkg::wordT lookup(input logic [23:0] addr);
        if (addr < ImageWords) begin
            return image[addr];
        end
        return 32'hEE00_0000 | 32'(addr);
    endfunction

    initial begin
        spiMiso = 1'b0;
        bitIdx = 0;
        header = '0;
    end

    always @(negedge spiCs) begin
        bitIdx = 0;
        header = '0;
    end

    // Mode 0 sampling on the rising edge
    always @(posedge spiSclk) begin
        if (!spiCs) begin
            if (bitIdx < 32) begin
                header = {header[30:0], spiMosi};
            end
            bitIdx++;
        end
    end

    // Data goes out on falling edges once the address is complete
    always @(negedge spiSclk) begin
        if (!spiCs && bitIdx == 32) begin
            if (header[31:24] != `BOOT_READ_CMD) begin
                badCmd = 1'b1;
            end
            outWord = lookup(header[23:0]);
            spiMiso = outWord[31];
        end else if (!spiCs && bitIdx > 32 && bitIdx < 64) begin
            spiMiso = outWord[63 - bitIdx];
        end
    end

    // Only complete frames count
    always @(posedge spiCs) begin
        if (bitIdx == 64) begin
            frameCount++;
        end
    end

endmodule

// ==== spiWordReader.sv ====
`timescale 1ns/1ps
`include "bootLoad_cfg.svh"

module spiWordReader (
    input  logic             Clock,
    input  logic             rst,
    input  bootPkg::readReqT readReq,
    input  logic             readReqValid,
    output logic             readReqReady,
    output bootPkg::readRspT readRsp,
    output logic             readRspValid,
    input  logic             readRspReady,
    output logic             spiCs,
    output logic             spiSclk,
    output logic             spiMosi,
    input  logic             spiMiso
);

    // Command byte, 24 address bits, 32 data bits
    localparam int FrameBits = 64;
    localparam int BitW = $clog2(FrameBits);
    localparam int DivW = $clog2(`BOOT_SPI_DIV + 1);
    localparam logic [DivW-1:0] DivMax = DivW'(`BOOT_SPI_DIV);

    bootPkg::spiStateT state;
    logic [DivW-1:0] divCnt;
    logic [BitW-1:0] bitCnt;
    logic [FrameBits-1:0] txShift;
    bootPkg::wordT rxData;

    logic halfDone;
    logic riseEdge;
    logic fallEdge;
    logic lastBit;
    logic reqFire;

    assign halfDone = (state == bootPkg::shift) && (divCnt == DivMax);
    assign riseEdge = halfDone && !spiSclk;
    assign fallEdge = halfDone && spiSclk;
    assign lastBit = (bitCnt == BitW'(FrameBits - 1));

    assign readReqReady = (state == bootPkg::idle);
    assign reqFire = readReqValid && readReqReady;

    assign readRsp = '{data: rxData};

    // Mode 0, MSB of the frame always sits on the line
    assign spiMosi = txShift[FrameBits-1];

    always_ff @(posedge Clock) begin
        if (rst) begin
            state <= bootPkg::idle;
            divCnt <= '0;
            bitCnt <= '0;
            spiCs <= 1'b1;
            spiSclk <= 1'b0;
            readRspValid <= 1'b0;
        end else begin
            case (state)
                bootPkg::idle: begin
                    if (readReqValid) begin
                        state <= bootPkg::shift;
                        spiCs <= 1'b0;
                        divCnt <= '0;
                        bitCnt <= '0;
                    end
                end
                bootPkg::shift: begin
                    // Counter restarts at 1, so the first half period gets
                    // one extra cycle of chip-select setup
                    if (halfDone) begin
                        divCnt <= DivW'(1);
                        spiSclk <= ~spiSclk;
                    end else begin
                        divCnt <= divCnt + 1'b1;
                    end
                    if (fallEdge) begin
                        bitCnt <= bitCnt + 1'b1;
                        if (lastBit) begin
                            state <= bootPkg::done;
                            spiCs <= 1'b1;
                        end
                    end
                end
                bootPkg::done: begin
                    // One cycle of cs high before the word is offered
                    if (!readRspValid) begin
                        readRspValid <= 1'b1;
                    end else if (readRspReady) begin
                        readRspValid <= 1'b0;
                        state <= bootPkg::idle;
                    end
                end
                default: begin
                    state <= bootPkg::idle;
                end
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (reqFire) begin
            txShift <= {`BOOT_READ_CMD, readReq.addr, 32'h0};
        end else if (fallEdge) begin
            txShift <= {txShift[FrameBits-2:0], 1'b0};
        end

        // Data phase is the upper half of the bit index
        if (riseEdge && bitCnt[BitW-1]) begin
            rxData <= {rxData[30:0], spiMiso};
        end
    end

endmodule
